//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = mipsExecTb
FILELIST  = filelist.f
OBJDIR    = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf $(OBJDIR)

//--- filelist.f
logic/mipsIsaPkg.sv
logic/aluPkg.sv
logic/aluCore.sv
logic/aluDecoder.sv
logic/regFile.sv
logic/execStage.sv
logic/mipsExecTop.sv
tb/mipsExecTb.sv

//--- logic/aluCore.sv
module aluCore (
	input  aluPkg::aluOp_t aluOp, // Function select from the decoder
	input  logic [31:0]    a,     // Operand A, rs or shamt
	input  logic [31:0]    b,     // Operand B, rt or immediate
	output logic [31:0]    aluResult,
	output logic           zero   // High when aluResult is zero
);

	logic [4:0] shiftAmount; // Only the low five bits of a count

	assign shiftAmount = a[4:0];

	always_comb begin
		// Operation select must be known whenever the ALU is evaluated
		assert final (!$isunknown(aluOp))
			else $error("aluCore: unknown ALU operation %b", aluOp);

		case (aluOp)
			aluPkg::ADD: begin
				aluResult = a + b; // Add, no overflow trap
			end
			aluPkg::SUB: begin
				aluResult = a - b; // Also used for beq/bne
			end
			aluPkg::MUL: begin
				aluResult = a * b; // Low 32 bits kept
			end
			aluPkg::AND: begin
				aluResult = a & b;
			end
			aluPkg::OR: begin
				aluResult = a | b;
			end
			aluPkg::NOR: begin
				aluResult = ~(a | b);
			end
			aluPkg::XOR: begin
				aluResult = a ^ b;
			end

			// Shifts move b, a gives the distance
			aluPkg::SLL: begin
				aluResult = b << shiftAmount;
			end
			aluPkg::SRL: begin
				aluResult = b >> shiftAmount; // Zero fill
			end

			// Compares give 1 or 0
			aluPkg::SLT: begin
				if ($signed(a) < $signed(b)) begin
					aluResult = 32'd1;
				end
				else begin
					aluResult = 32'd0;
				end
			end
			aluPkg::SLTU: begin
				if (a < b) begin
					aluResult = 32'd1; // Plain unsigned order
				end
				else begin
					aluResult = 32'd0;
				end
			end

			aluPkg::LUI: begin
				aluResult = {b[15:0], 16'h0000}; // Immediate to upper half
			end

			default: begin
				aluResult = 32'd0; // Unused codes
			end
		endcase
	end

	// Zero flag follows the result for every operation
	assign zero = (aluResult == 32'd0);

endmodule

//--- logic/aluDecoder.sv
module aluDecoder (
	input  mipsIsaPkg::instr_u   instr, // Raw word, read through both views
	output aluPkg::decodedCtrl_t ctrl
);

	logic [31:0] immSigned; // For arithmetic, compares and branches
	logic [31:0] immZero;   // For the logical immediates

	assign immSigned = {{16{instr.i.imm16[15]}}, instr.i.imm16};
	assign immZero   = {16'h0000, instr.i.imm16};

	always_comb begin
		ctrl = '0; // No write, no branch, operand B from rt
		ctrl.aluOp = aluPkg::ADD;
		ctrl.destReg = instr.i.rt; // I-type destination

		case (instr.i.opcode)
			mipsIsaPkg::opRType: begin
				ctrl.destReg = instr.r.rd; // R-type destination
				ctrl.writesReg = 1'b1;
				case (instr.r.funct)
					mipsIsaPkg::fnAdd, mipsIsaPkg::fnAddu: ctrl.aluOp = aluPkg::ADD;
					mipsIsaPkg::fnSub, mipsIsaPkg::fnSubu: ctrl.aluOp = aluPkg::SUB;
					mipsIsaPkg::fnMul:  ctrl.aluOp = aluPkg::MUL;
					mipsIsaPkg::fnAnd:  ctrl.aluOp = aluPkg::AND;
					mipsIsaPkg::fnOr:   ctrl.aluOp = aluPkg::OR;
					mipsIsaPkg::fnNor:  ctrl.aluOp = aluPkg::NOR;
					mipsIsaPkg::fnXor:  ctrl.aluOp = aluPkg::XOR;
					mipsIsaPkg::fnSlt:  ctrl.aluOp = aluPkg::SLT;
					mipsIsaPkg::fnSltu: ctrl.aluOp = aluPkg::SLTU;
					mipsIsaPkg::fnSll: begin
						ctrl.aluOp = aluPkg::SLL;
						ctrl.shiftByShamt = 1'b1; // Distance from shamt
					end
					mipsIsaPkg::fnSrl: begin
						ctrl.aluOp = aluPkg::SRL;
						ctrl.shiftByShamt = 1'b1;
					end
					mipsIsaPkg::fnSllv: ctrl.aluOp = aluPkg::SLL; // Distance from rs
					mipsIsaPkg::fnSrlv: ctrl.aluOp = aluPkg::SRL;
					default: ctrl.illegal = 1'b1; // Unknown funct
				endcase
			end

			// Immediates, sign-extended
			mipsIsaPkg::opAddi, mipsIsaPkg::opAddiu: begin
				ctrl.aluOp = aluPkg::ADD;
				ctrl.immValue = immSigned;
			end
			mipsIsaPkg::opSlti: begin
				ctrl.aluOp = aluPkg::SLT;
				ctrl.immValue = immSigned;
			end
			mipsIsaPkg::opSltiu: begin
				ctrl.aluOp = aluPkg::SLTU; // Extended signed, compared unsigned
				ctrl.immValue = immSigned;
			end

			// Immediates, zero-extended
			mipsIsaPkg::opAndi: begin
				ctrl.aluOp = aluPkg::AND;
				ctrl.immValue = immZero;
			end
			mipsIsaPkg::opOri: begin
				ctrl.aluOp = aluPkg::OR;
				ctrl.immValue = immZero;
			end
			mipsIsaPkg::opXori: begin
				ctrl.aluOp = aluPkg::XOR;
				ctrl.immValue = immZero;
			end
			mipsIsaPkg::opLui: begin
				ctrl.aluOp = aluPkg::LUI;
				ctrl.immValue = immZero;
			end

			// Branches compare through SUB
			mipsIsaPkg::opBeq:  ctrl.branchCond = aluPkg::EQ;
			mipsIsaPkg::opBne:  ctrl.branchCond = aluPkg::NE;
			mipsIsaPkg::opBlez: ctrl.branchCond = aluPkg::LEZ;
			mipsIsaPkg::opBgtz: ctrl.branchCond = aluPkg::GTZ;

			default: ctrl.illegal = 1'b1; // Unknown opcode
		endcase

		// Opcode groups that share settings
		case (instr.i.opcode)
			mipsIsaPkg::opBeq, mipsIsaPkg::opBne, mipsIsaPkg::opBlez, mipsIsaPkg::opBgtz: begin
				ctrl.isBranch = 1'b1;
				ctrl.aluOp = aluPkg::SUB;
				ctrl.immValue = immSigned; // Word offset
			end
			mipsIsaPkg::opRType: begin
				ctrl.useImm = 1'b0;
			end
			default: begin
				ctrl.useImm = !ctrl.illegal;
				ctrl.writesReg = !ctrl.illegal;
			end
		endcase

		// r0 is never written, illegal words write nothing
		if (ctrl.illegal || ctrl.destReg == 5'd0) begin
			ctrl.writesReg = 1'b0;
		end
	end

endmodule

//--- logic/aluPkg.sv
//////////////////////////////////////////////////////////////////////
// Execution-side types shared by decoder, ALU and execute stage
//////////////////////////////////////////////////////////////////////
package aluPkg;

	// ALU function select, 5 bits wide
	typedef enum logic [4:0] {
		ADD  = 5'd0,
		SUB  = 5'd1,
		MUL  = 5'd2,
		AND  = 5'd3,
		OR   = 5'd4,
		NOR  = 5'd5,
		XOR  = 5'd6,
		SLL  = 5'd7,  // b shifted left by a
		SRL  = 5'd8,  // b shifted right by a, logical
		SLT  = 5'd9,  // Signed less-than
		SLTU = 5'd10, // Unsigned less-than
		LUI  = 5'd11  // b low half into upper half
	} aluOp_t;

	// Branch conditions, all on rs (and rt for EQ/NE)
	typedef enum logic [1:0] {
		EQ  = 2'd0,
		NE  = 2'd1,
		LEZ = 2'd2,
		GTZ = 2'd3
	} branchCond_t;

	// Decoder output
	typedef struct packed {
		aluOp_t      aluOp;
		logic        useImm;       // Operand B from immValue
		logic        shiftByShamt; // Operand A from shamt
		logic [31:0] immValue;     // Already extended
		logic        writesReg;    // Never set for r0
		logic [4:0]  destReg;
		logic        isBranch;
		branchCond_t branchCond;
		logic        illegal;
	} decodedCtrl_t;

	// Registered outcome of one instruction
	typedef struct packed {
		logic        wbValid;
		logic [4:0]  wbReg;
		logic [31:0] wbData;
		logic        branchValid;
		logic        branchTaken;
		logic [31:0] branchTarget;
		logic        illegalInstr;
	} execResult_t;

endpackage

//--- logic/execStage.sv
module execStage (
	input  logic                 Clk,
	input  logic                 rst,
	input  logic                 instrValid, // Plain strobe without handshake
	input  logic [31:0]          pc,
	input  mipsIsaPkg::instr_u   instr,      // Only shamt is taken from here
	input  aluPkg::decodedCtrl_t ctrl,
	input  logic [31:0]          rsValue,
	input  logic [31:0]          rtValue,
	output aluPkg::execResult_t  result
);

	logic [31:0] opA;          // ALU operand A
	logic [31:0] opB;          // ALU operand B
	logic [31:0] aluResult;
	logic        zero;
	logic        takenNow;     // Branch condition this cycle
	logic [31:0] targetNow;    // pc + 4 + offset * 4

	logic        wbValidQ;     // Strobes cleared by reset
	logic        branchValidQ;
	logic        branchTakenQ;
	logic        illegalQ;
	logic [4:0]  wbRegQ;       // Payload
	logic [31:0] wbDataQ;
	logic [31:0] targetQ;

	//////////////////////////////////////////////////////////////////////
	// Operand select and ALU
	//////////////////////////////////////////////////////////////////////
	assign opA = ctrl.shiftByShamt ? {27'd0, instr.r.shamt} : rsValue;
	assign opB = ctrl.useImm ? ctrl.immValue : rtValue;

	aluCore aluCore_i (
		.aluOp     (ctrl.aluOp),
		.a         (opA),
		.b         (opB),
		.aluResult (aluResult),
		.zero      (zero)
	);

	//////////////////////////////////////////////////////////////////////
	// Branch resolution
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		case (ctrl.branchCond)
			aluPkg::EQ:  takenNow = zero;  // rs - rt == 0
			aluPkg::NE:  takenNow = !zero;
			aluPkg::LEZ: takenNow = rsValue[31] || (rsValue == 32'd0); // Signed <= 0
			default:     takenNow = !rsValue[31] && (rsValue != 32'd0); // GTZ
		endcase
	end

	assign targetNow = pc + 32'd4 + {ctrl.immValue[29:0], 2'b00};

	//////////////////////////////////////////////////////////////////////
	// Result register with one cycle of latency
	//////////////////////////////////////////////////////////////////////
	// Decoder flags keep the three strobes apart
	always_ff @(posedge Clk) begin
		if (rst) begin
			wbValidQ     <= 1'b0;
			branchValidQ <= 1'b0;
			branchTakenQ <= 1'b0;
			illegalQ     <= 1'b0;
		end
		else begin
			wbValidQ     <= instrValid && ctrl.writesReg;
			branchValidQ <= instrValid && ctrl.isBranch;
			branchTakenQ <= instrValid && ctrl.isBranch && takenNow;
			illegalQ     <= instrValid && ctrl.illegal;
		end
	end

	always_ff @(posedge Clk) begin
		wbRegQ  <= ctrl.destReg;
		wbDataQ <= aluResult;
		targetQ <= targetNow;
	end

	assign result = '{
		wbValid:      wbValidQ,
		wbReg:        wbRegQ,
		wbData:       wbDataQ,
		branchValid:  branchValidQ,
		branchTaken:  branchTakenQ,
		branchTarget: targetQ,
		illegalInstr: illegalQ
	};

	// One kind of outcome per instruction
	oneStrobe: assert property (
		@(posedge Clk) disable iff (rst)
		$onehot0({result.wbValid, result.branchValid, result.illegalInstr})
	) else $error("execStage: more than one result strobe");

endmodule

//--- logic/mipsExecTop.sv
module mipsExecTop (
	input  logic                Clk,
	input  logic                rst,
	input  logic                instrValid, // One instruction per cycle at most
	input  mipsIsaPkg::instr_u  instr,
	input  logic [31:0]         pc,
	output aluPkg::execResult_t result      // One cycle after the instruction
);

	aluPkg::decodedCtrl_t ctrl; // Decoder to execute stage
	logic [31:0]          rsValue;
	logic [31:0]          rtValue;

	//////////////////////////////////////////////////////////////////////
	// Decode and register read, same cycle
	//////////////////////////////////////////////////////////////////////
	aluDecoder decoder_i (
		.instr (instr),
		.ctrl  (ctrl)
	);

	// Writeback comes straight from the registered result
	regFile regFile_i (
		.Clk     (Clk),
		.rst     (rst),
		.rdAddrA (instr.r.rs),
		.rdAddrB (instr.r.rt),
		.wrEn    (result.wbValid),
		.wrAddr  (result.wbReg),
		.wrData  (result.wbData),
		.rdDataA (rsValue),
		.rdDataB (rtValue)
	);

	//////////////////////////////////////////////////////////////////////
	// Execute and register the outcome
	//////////////////////////////////////////////////////////////////////
	execStage execStage_i (
		.Clk        (Clk),
		.rst        (rst),
		.instrValid (instrValid),
		.pc         (pc),
		.instr      (instr),
		.ctrl       (ctrl),
		.rsValue    (rsValue),
		.rtValue    (rtValue),
		.result     (result)
	);

endmodule

//--- logic/mipsIsaPkg.sv
//////////////////////////////////////////////////////////////////////
// MIPS32 instruction encoding for the execute slice
//////////////////////////////////////////////////////////////////////
package mipsIsaPkg;

	typedef logic [5:0] opcode_t; // Bits 31:26 of every instruction
	typedef logic [5:0] funct_t;  // Bits 5:0, R-type only

	// Primary opcodes
	localparam opcode_t opRType = 6'h00; // SPECIAL, operation sits in funct
	localparam opcode_t opBeq   = 6'h04;
	localparam opcode_t opBne   = 6'h05;
	localparam opcode_t opBlez  = 6'h06;
	localparam opcode_t opBgtz  = 6'h07;
	localparam opcode_t opAddi  = 6'h08;
	localparam opcode_t opAddiu = 6'h09;
	localparam opcode_t opSlti  = 6'h0a;
	localparam opcode_t opSltiu = 6'h0b;
	localparam opcode_t opAndi  = 6'h0c;
	localparam opcode_t opOri   = 6'h0d;
	localparam opcode_t opXori  = 6'h0e;
	localparam opcode_t opLui   = 6'h0f;

	// R-type function codes
	localparam funct_t fnSll  = 6'h00; // Shift by shamt
	localparam funct_t fnSrl  = 6'h02;
	localparam funct_t fnSllv = 6'h04; // Shift by rs
	localparam funct_t fnSrlv = 6'h06;
	localparam funct_t fnMul  = 6'h18; // Low word of the product only
	localparam funct_t fnAdd  = 6'h20;
	localparam funct_t fnAddu = 6'h21;
	localparam funct_t fnSub  = 6'h22;
	localparam funct_t fnSubu = 6'h23;
	localparam funct_t fnAnd  = 6'h24;
	localparam funct_t fnOr   = 6'h25;
	localparam funct_t fnXor  = 6'h26;
	localparam funct_t fnNor  = 6'h27;
	localparam funct_t fnSlt  = 6'h2a; // Signed compare
	localparam funct_t fnSltu = 6'h2b; // Unsigned compare

	// Register-register format
	typedef struct packed {
		opcode_t    opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funct_t     funct;
	} rType_t;

	// Immediate format, also used by the branches
	typedef struct packed {
		opcode_t     opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} iType_t;

	// One word, two views
	typedef union packed {
		rType_t r;
		iType_t i;
	} instr_u;

endpackage

//--- logic/regFile.sv
module regFile (
	input  logic        Clk,
	input  logic        rst,
	input  logic [4:0]  rdAddrA, // rs
	input  logic [4:0]  rdAddrB, // rt
	input  logic        wrEn,    // From the registered writeback
	input  logic [4:0]  wrAddr,
	input  logic [31:0] wrData,
	output logic [31:0] rdDataA,
	output logic [31:0] rdDataB
);

	logic [31:0] regs [32]; // Entry 0 stays zero

	always_ff @(posedge Clk) begin
		if (rst) begin
			for (int idx = 0; idx < 32; idx++) begin
				regs[idx] <= 32'd0; // All registers read zero after reset
			end
		end
		else if (wrEn && wrAddr != 5'd0) begin
			regs[wrAddr] <= wrData; // r0 ignores writes
		end
	end

	// Read port A with write-through
	always_comb begin
		if (rdAddrA == 5'd0) begin
			rdDataA = 32'd0; // Hard-wired r0
		end
		else if (wrEn && wrAddr == rdAddrA) begin
			rdDataA = wrData; // Pending write wins
		end
		else begin
			rdDataA = regs[rdAddrA];
		end
	end

	// Read port B, same rule
	always_comb begin
		if (rdAddrB == 5'd0) begin
			rdDataB = 32'd0;
		end
		else if (wrEn && wrAddr == rdAddrB) begin
			rdDataB = wrData;
		end
		else begin
			rdDataB = regs[rdAddrB];
		end
	end

	// Decoder drops r0 destinations, so writeback never targets r0
	noWriteToZero: assert property (
		@(posedge Clk) disable iff (rst) wrEn |-> (wrAddr != 5'd0)
	) else $error("regFile: write enabled to r0");

endmodule

//--- tb/mipsExecInput.txt
# pc instr wbValid wbReg wbData branchValid branchTaken branchTarget illegalInstr, all hex
# Expected values assume every register starts at zero; wbReg/wbData unused without wbValid
00400000 20010007 1 01 00000007 0 0 00000000 0
00400004 2002fffd 1 02 fffffffd 0 0 00000000 0
00400008 00221820 1 03 00000004 0 0 00000000 0
0040000c 00222022 1 04 0000000a 0 0 00000000 0
00400010 00412823 1 05 fffffff6 0 0 00000000 0
00400014 00223018 1 06 ffffffeb 0 0 00000000 0
00400018 00223824 1 07 00000005 0 0 00000000 0
0040001c 00224025 1 08 ffffffff 0 0 00000000 0
00400020 00224827 1 09 00000000 0 0 00000000 0
00400024 00225026 1 0a fffffffa 0 0 00000000 0
0040002c 304c8001 1 0c 00008001 0 0 00000000 0
00400030 340df00f 1 0d 0000f00f 0 0 00000000 0
00400034 384effff 1 0e ffff0002 0 0 00000000 0
00400038 3c0f1234 1 0f 12340000 0 0 00000000 0
0040003c 00018100 1 10 00000070 0 0 00000000 0
00400040 00028a02 1 11 00ffffff 0 0 00000000 0
00400044 006f9004 1 12 23400000 0 0 00000000 0
00400048 00829806 1 13 003fffff 0 0 00000000 0
0040004c 0041a02a 1 14 00000001 0 0 00000000 0
00400050 0041a82b 1 15 00000000 0 0 00000000 0
00400058 2c37ffff 1 17 00000001 0 0 00000000 0
0040005c 2838ffff 1 18 00000000 0 0 00000000 0
00400060 20190100 1 19 00000100 0 0 00000000 0
00400064 23390023 1 19 00000123 0 0 00000000 0
00400068 0339d020 1 1a 00000246 0 0 00000000 0
0040006c 20200005 0 00 00000000 0 0 00000000 0
00400070 0001d820 1 1b 00000007 0 0 00000000 0
00400074 10210004 0 00 00000000 1 1 00400088 0
00400078 10220004 0 00 00000000 1 0 0040008c 0
0040007c 1422fff8 0 00 00000000 1 1 00400060 0
00400080 143b0002 0 00 00000000 1 0 0040008c 0
00400084 18400003 0 00 00000000 1 1 00400094 0
00400088 18200003 0 00 00000000 1 0 00400098 0
0040008c 1c20ffff 0 00 00000000 1 1 0040008c 0
00400090 1c000001 0 00 00000000 1 0 00400098 0
00400094 fc000000 0 00 00000000 0 0 00000000 1
00400098 0022283f 0 00 00000000 0 0 00000000 1
0040009c 035be020 1 1c 0000024d 0 0 00000000 0
004000a4 00a0f025 1 1e fffffff6 0 0 00000000 0

//--- tb/mipsExecTb.sv
module mipsExecTb;

	logic                Clk;
	logic                rst;
	logic                instrValid;
	mipsIsaPkg::instr_u  instr;
	logic [31:0]         pc;
	aluPkg::execResult_t result;

	int mismatches; // Wrong output values
	int timeouts;   // Waits that ran out
	int failures;   // File trouble and misplaced strobes
	int seed;       // Bubble count source

	mipsExecTop dut_i (
		.Clk        (Clk),
		.rst        (rst),
		.instrValid (instrValid),
		.instr      (instr),
		.pc         (pc),
		.result     (result)
	);

	always #50 Clk = ~Clk; // Period 100

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////
	task automatic compareField(input string name, input logic [31:0] got,
			input logic [31:0] exp, input logic [31:0] atPc);
		assert (got === exp)
			else begin
				$display("Mismatch %s at pc %h: got %h expected %h", name, atPc, got, exp);
				mismatches++;
			end
	endtask

	// Reset for 16 cycles before the strobes settle low
	task automatic applyReset();
		int cycles;
		cycles = 0;
		rst = 1'b1;
		repeat (16) @(negedge Clk);
		rst = 1'b0;
		while (result.wbValid || result.branchValid || result.illegalInstr) begin
			cycles++;
			if (cycles > 8) begin
				$display("Timeout: result strobes still high after reset release");
				timeouts++;
				break;
			end
			@(negedge Clk);
		end
	endtask

	// Outcome is due one cycle after issue
	task automatic awaitOutcome(input logic expectStrobe);
		int cycles;
		cycles = 0;
		@(negedge Clk);
		while (expectStrobe && !(result.wbValid || result.branchValid || result.illegalInstr)) begin
			instrValid = 1'b0; // No reissue while waiting
			cycles++;
			if (cycles > 4) begin
				$display("Timeout: no result strobe for the instruction at pc %h", pc);
				timeouts++;
				break;
			end
			@(negedge Clk);
		end
		if (cycles > 0 && cycles <= 4) begin
			$display("Late result strobe for pc %h after %0d extra cycles", pc, cycles);
			failures++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus from the data file checked line by line
	//////////////////////////////////////////////////////////////////////
	initial begin
		int fd;
		int fields;
		int bubbles;
		int vectors;
		string line;
		logic [31:0] vecPc, vecInstr;
		logic [31:0] expWbValid, expWbReg, expWbData;
		logic [31:0] expBrValid, expBrTaken, expBrTarget, expIllegal;

		Clk = 1'b0;
		rst = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		pc = '0;
		mismatches = 0;
		timeouts = 0;
		failures = 0;
		vectors = 0;
		seed = 32'h286e;

		applyReset();
		fd = $fopen("tb/mipsExecInput.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file tb/mipsExecInput.txt");
			failures++;
		end
		else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() < 2 || line.getc(0) == "#") begin
					continue; // Blank or column notes
				end
				fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h", vecPc, vecInstr,
					expWbValid, expWbReg, expWbData, expBrValid, expBrTaken,
					expBrTarget, expIllegal);
				if (fields != 9) begin
					$display("Malformed stimulus line: %s", line);
					failures++;
					continue;
				end

				pc = vecPc; // We sit on a falling edge here
				instr = vecInstr;
				instrValid = 1'b1;
				awaitOutcome(expWbValid[0] || expBrValid[0] || expIllegal[0]);

				compareField("wbValid", 32'(result.wbValid), expWbValid, vecPc);
				compareField("branchValid", 32'(result.branchValid), expBrValid, vecPc);
				compareField("branchTaken", 32'(result.branchTaken), expBrTaken, vecPc);
				compareField("illegalInstr", 32'(result.illegalInstr), expIllegal, vecPc);
				if (expWbValid[0]) begin
					compareField("wbReg", 32'(result.wbReg), expWbReg, vecPc);
					compareField("wbData", result.wbData, expWbData, vecPc);
				end
				if (expBrValid[0]) begin
					compareField("branchTarget", result.branchTarget, expBrTarget, vecPc);
				end
				vectors++;

				// Zero to two idle cycles where none means back-to-back issue
				instrValid = 1'b0;
				bubbles = $unsigned($random(seed)) % 3;
				repeat (bubbles) begin
					@(negedge Clk);
					assert (!(result.wbValid || result.branchValid || result.illegalInstr))
						else begin
							$display("A result strobe was raised during an idle cycle");
							failures++;
						end
				end
			end
			$fclose(fd);
		end

		if (vectors == 0) begin
			$display("No stimulus lines were read from the data file");
			failures++;
		end
		$display("Vectors %0d, mismatches %0d, timeouts %0d, other errors %0d",
			vectors, mismatches, timeouts, failures);
		if (mismatches == 0 && timeouts == 0 && failures == 0) begin
			$display("all tests passed");
		end
		else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule
